/* exe_params.svh */
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

`define DATA_WIDTH    32
`define ADDR_WIDTH    32
`define RADDR_WIDTH   5
`define SHAMT_WIDTH   5

// rv32i major opcodes
`define OP_IMM        7'b0010011
`define OP_REG        7'b0110011
`define OP_LUI        7'b0110111
`define OP_AUIPC      7'b0010111
`define OP_LOAD       7'b0000011
`define OP_STORE      7'b0100011
`define OP_BRANCH     7'b1100011
`define OP_JAL        7'b1101111
`define OP_JALR       7'b1100111

`define F7_BASE       7'b0000000
`define F7_ALT        7'b0100000    // sub, sra, srai

// alu operation codes
`define ALU_ADD       4'd0
`define ALU_SUB       4'd1
`define ALU_AND       4'd2
`define ALU_OR        4'd3
`define ALU_XOR       4'd4
`define ALU_SLT       4'd5
`define ALU_SLTU      4'd6
`define ALU_SLL       4'd7
`define ALU_SRL       4'd8
`define ALU_SRA       4'd9          // highest defined code

// memory stage access codes
`define MEM_NOP       4'd0
`define MEM_LB        4'd1
`define MEM_LH        4'd2
`define MEM_LW        4'd3
`define MEM_LBU       4'd4
`define MEM_LHU       4'd5
`define MEM_SB        4'd6
`define MEM_SH        4'd7
`define MEM_SW        4'd8

`endif

/* exe_pkg.sv */
`include "exe_params.svh"

package exe_pkg;

    typedef logic [`DATA_WIDTH-1:0]  data_t;     // operand or result word
    typedef logic [`ADDR_WIDTH-1:0]  addr_t;     // pc or memory address
    typedef logic [`RADDR_WIDTH-1:0] raddr_t;    // register file index

    // selected alu operation
    typedef logic [3:0] alu_op_t;

    // branch condition / access size field
    typedef logic [2:0] funct3_t;

    typedef logic [3:0] mem_op_t;                // access code to mem stage

endpackage

/* inst_decode.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module inst_decode (
    input  exe_pkg::data_t   inst_i,
    input  logic             reg_we_i,
    output exe_pkg::alu_op_t alu_op_o,
    output logic             alu_valid_o,
    output logic             branch_en_o,
    output logic             jal_en_o,
    output logic             jalr_en_o,
    output logic             load_en_o,
    output logic             store_en_o,
    output logic             write_en_o,
    output logic             link_sel_o,
    output exe_pkg::funct3_t funct3_o,
    output exe_pkg::data_t   imm_b_o,
    output exe_pkg::data_t   imm_j_o,
    output exe_pkg::data_t   imm_i_o,
    output exe_pkg::data_t   imm_s_o
);
    import exe_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    funct3_t    funct3;
    logic       f7_base;
    logic       f7_alt;
    logic       illegal;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign f7_base = (funct7 == `F7_BASE);
    assign f7_alt  = (funct7 == `F7_ALT);

    assign funct3_o = funct3;

    assign imm_i_o = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // same funct3 map for op-imm and op
    function automatic alu_op_t alu_op_of(input funct3_t f3, input logic alt);
        case (f3)
            3'b000:  return alt ? `ALU_SUB : `ALU_ADD;
            3'b001:  return `ALU_SLL;
            3'b010:  return `ALU_SLT;
            3'b011:  return `ALU_SLTU;
            3'b100:  return `ALU_XOR;
            3'b101:  return alt ? `ALU_SRA : `ALU_SRL;
            3'b110:  return `ALU_OR;
            default: return `ALU_AND;
        endcase
    endfunction

    always_comb begin
        alu_op_o    = `ALU_ADD;
        alu_valid_o = 1'b0;
        branch_en_o = 1'b0;
        jal_en_o    = 1'b0;
        jalr_en_o   = 1'b0;
        load_en_o   = 1'b0;
        store_en_o  = 1'b0;
        write_en_o  = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            `OP_IMM: begin
                alu_valid_o = 1'b1;
                write_en_o  = reg_we_i;
                alu_op_o    = alu_op_of(funct3, f7_alt && funct3 == 3'b101);
                // upper bits are immediate except for shifts
                illegal = (funct3 == 3'b001 && !f7_base) ||
                          (funct3 == 3'b101 && !(f7_base || f7_alt));
            end
            `OP_REG: begin
                alu_valid_o = 1'b1;
                write_en_o  = 1'b1;
                alu_op_o    = alu_op_of(funct3, f7_alt);
                // alt only for sub/sra, mul/div funct7 lands here as well
                illegal = !(f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            `OP_LUI, `OP_AUIPC: begin
                alu_valid_o = 1'b1;     // op1 + op2 from id stage
                write_en_o  = reg_we_i;
            end
            `OP_LOAD: begin
                load_en_o  = 1'b1;
                write_en_o = 1'b1;
                illegal    = funct3 inside {3'b011, 3'b110, 3'b111};
            end
            `OP_STORE: begin
                store_en_o = 1'b1;
                illegal    = funct3[2] || (funct3[1:0] == 2'b11);
            end
            `OP_BRANCH: begin
                branch_en_o = 1'b1;
                illegal     = (funct3[2:1] == 2'b01);
            end
            `OP_JAL: begin
                jal_en_o   = 1'b1;
                write_en_o = reg_we_i;
            end
            `OP_JALR: begin
                jalr_en_o  = 1'b1;
                write_en_o = reg_we_i;
                illegal    = (funct3 != 3'b000);
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            alu_valid_o = 1'b0;
            branch_en_o = 1'b0;
            jal_en_o    = 1'b0;
            jalr_en_o   = 1'b0;
            load_en_o   = 1'b0;
            store_en_o  = 1'b0;
            write_en_o  = 1'b0;
        end
    end

    assign link_sel_o = jal_en_o | jalr_en_o;

endmodule

/* int_alu.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module int_alu (
    input  logic             clk_i,
    input  logic             rst_i,
    input  exe_pkg::data_t   op1_i,
    input  exe_pkg::data_t   op2_i,
    input  exe_pkg::alu_op_t alu_op_i,
    input  logic             alu_valid_i,
    output exe_pkg::data_t   result_o
);
    import exe_pkg::*;

    logic [`SHAMT_WIDTH-1:0] shamt;
    logic                    lt_s;
    logic                    lt_u;
    data_t                   res;

    assign shamt = op2_i[`SHAMT_WIDTH-1:0];    // low five bits only
    assign lt_s  = ($signed(op1_i) < $signed(op2_i));
    assign lt_u  = (op1_i < op2_i);

    always_comb begin
        case (alu_op_i)
            `ALU_ADD:  res = op1_i + op2_i;
            `ALU_SUB:  res = op1_i - op2_i;
            `ALU_AND:  res = op1_i & op2_i;
            `ALU_OR:   res = op1_i | op2_i;
            `ALU_XOR:  res = op1_i ^ op2_i;
            `ALU_SLT:  res = {{(`DATA_WIDTH-1){1'b0}}, lt_s};
            `ALU_SLTU: res = {{(`DATA_WIDTH-1){1'b0}}, lt_u};
            `ALU_SLL:  res = op1_i << shamt;
            `ALU_SRL:  res = op1_i >> shamt;
            `ALU_SRA:  res = $signed(op1_i) >>> shamt;
            default:   res = '0;
        endcase
    end

    // loads and non-alu classes see zero here
    assign result_o = alu_valid_i ? res : '0;

    // decoder only hands over defined codes
    op_known: assert property (@(posedge clk_i) disable iff (rst_i)
        alu_valid_i |-> (alu_op_i <= `ALU_SRA))
        else $error("int_alu: undefined operation %0d", alu_op_i);

endmodule

/* branch_unit.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module branch_unit (
    input  exe_pkg::data_t   op1_i,
    input  exe_pkg::data_t   op2_i,
    input  exe_pkg::addr_t   pc_i,
    input  exe_pkg::funct3_t funct3_i,
    input  logic             branch_en_i,
    input  logic             jal_en_i,
    input  logic             jalr_en_i,
    input  exe_pkg::data_t   imm_b_i,
    input  exe_pkg::data_t   imm_j_i,
    input  exe_pkg::data_t   imm_i_i,
    output logic             taken_o,
    output exe_pkg::addr_t   target_o,
    output exe_pkg::addr_t   link_o
);
    import exe_pkg::*;

    logic  cond;
    logic  f3_defined;
    addr_t branch_target;

    assign f3_defined    = (funct3_i[2:1] != 2'b01);
    assign branch_target = f3_defined ? pc_i + imm_b_i : '0;

    always_comb begin
        case (funct3_i)
            3'b000:  cond = (op1_i == op2_i);                       // beq
            3'b001:  cond = (op1_i != op2_i);                       // bne
            3'b100:  cond = ($signed(op1_i) < $signed(op2_i));
            3'b101:  cond = ($signed(op1_i) >= $signed(op2_i));
            3'b110:  cond = (op1_i < op2_i);                        // bltu
            3'b111:  cond = (op1_i >= op2_i);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        if (jal_en_i) begin
            taken_o  = 1'b1;
            target_o = pc_i + imm_j_i;
        end else if (jalr_en_i) begin
            taken_o  = 1'b1;
            target_o = op1_i + imm_i_i;     // bit 0 left as computed
        end else if (branch_en_i) begin
            taken_o  = cond;
            target_o = branch_target;
        end
    end

    assign link_o = pc_i + addr_t'(4);

endmodule

/* lsu_agu.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module lsu_agu (
    input  exe_pkg::data_t   op1_i,
    input  exe_pkg::data_t   op2_i,
    input  exe_pkg::funct3_t funct3_i,
    input  logic             load_en_i,
    input  logic             store_en_i,
    input  exe_pkg::data_t   imm_i_i,
    input  exe_pkg::data_t   imm_s_i,
    output exe_pkg::addr_t   addr_o,
    output exe_pkg::data_t   wdata_o,
    output logic             we_o,
    output exe_pkg::mem_op_t op_o
);
    import exe_pkg::*;

    data_t offset;

    assign offset = store_en_i ? imm_s_i : imm_i_i;

    always_comb begin
        addr_o  = '0;
        wdata_o = '0;
        we_o    = 1'b0;
        op_o    = `MEM_NOP;
        if (load_en_i || store_en_i) begin
            addr_o = op1_i + offset;
        end
        if (load_en_i) begin
            case (funct3_i)
                3'b000:  op_o = `MEM_LB;
                3'b001:  op_o = `MEM_LH;
                3'b010:  op_o = `MEM_LW;
                3'b100:  op_o = `MEM_LBU;
                3'b101:  op_o = `MEM_LHU;
                default: op_o = `MEM_NOP;
            endcase
        end else if (store_en_i) begin
            wdata_o = op2_i;        // rs2 value
            we_o    = 1'b1;
            case (funct3_i)
                3'b000:  op_o = `MEM_SB;
                3'b001:  op_o = `MEM_SH;
                3'b010:  op_o = `MEM_SW;
                default: op_o = `MEM_NOP;
            endcase
        end
    end

endmodule

/* exe_mem_reg.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module exe_mem_reg (
    input  logic             clk_i,
    input  logic             rst_i,
    input  exe_pkg::raddr_t  reg_waddr_i,
    input  logic             write_en_i,
    input  logic             link_sel_i,
    input  exe_pkg::data_t   alu_result_i,
    input  exe_pkg::data_t   link_i,
    input  exe_pkg::addr_t   mem_addr_i,
    input  exe_pkg::data_t   mem_data_i,
    input  logic             mem_we_i,
    input  exe_pkg::mem_op_t mem_op_i,
    input  logic             jump_taken_i,
    input  exe_pkg::addr_t   jump_target_i,
    output exe_pkg::raddr_t  reg_waddr_o,
    output logic             reg_we_o,
    output exe_pkg::data_t   reg_wdata_o,
    output exe_pkg::addr_t   mem_addr_o,
    output exe_pkg::data_t   mem_data_o,
    output logic             mem_we_o,
    output exe_pkg::mem_op_t mem_op_o,
    output exe_pkg::addr_t   jump_addr_o,
    output logic             jump_enable_o
);
    import exe_pkg::*;

    raddr_t waddr_d;
    data_t  wdata_d;

    // jumps write back pc + 4
    assign wdata_d = !write_en_i ? '0 : (link_sel_i ? link_i : alu_result_i);
    assign waddr_d = write_en_i ? reg_waddr_i : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            reg_waddr_o   <= '0;
            reg_we_o      <= 1'b0;
            reg_wdata_o   <= '0;
            mem_addr_o    <= '0;
            mem_data_o    <= '0;
            mem_we_o      <= 1'b0;
            mem_op_o      <= `MEM_NOP;
            jump_addr_o   <= '0;
            jump_enable_o <= 1'b0;
        end else begin
            reg_waddr_o   <= waddr_d;
            reg_we_o      <= write_en_i;
            reg_wdata_o   <= wdata_d;
            mem_addr_o    <= mem_addr_i;
            mem_data_o    <= mem_data_i;
            mem_we_o      <= mem_we_i;
            mem_op_o      <= mem_op_i;
            jump_addr_o   <= jump_target_i;
            jump_enable_o <= jump_taken_i;
        end
    end

    // only stores touch memory, and a store never writes a register
    no_dual_write: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_we_o && reg_we_o))
        else $error("exe_mem_reg: register and memory write together");

    store_code: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_we_o |-> (mem_op_o inside {`MEM_SB, `MEM_SH, `MEM_SW}))
        else $error("exe_mem_reg: memory write with access code %0d", mem_op_o);

endmodule

/* exe_top.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module exe_top (
    input  logic             clk_i,
    input  logic             rst_i,
    input  exe_pkg::data_t   op1_i,
    input  exe_pkg::data_t   op2_i,
    input  logic             reg_we_i,
    input  exe_pkg::raddr_t  reg_waddr_i,
    input  exe_pkg::data_t   inst_i,
    input  exe_pkg::addr_t   inst_addr_i,
    output exe_pkg::raddr_t  reg_waddr_o,
    output logic             reg_we_o,
    output exe_pkg::data_t   reg_wdata_o,
    output exe_pkg::addr_t   mem_addr_o,
    output exe_pkg::data_t   mem_data_o,
    output logic             mem_we_o,
    output exe_pkg::mem_op_t mem_op_o,
    output exe_pkg::addr_t   jump_addr_o,
    output logic             jump_enable_o
);
    import exe_pkg::*;

    alu_op_t alu_op;
    logic    alu_valid;
    logic    branch_en;
    logic    jal_en;
    logic    jalr_en;
    logic    load_en;
    logic    store_en;
    logic    write_en;
    logic    link_sel;
    funct3_t funct3;
    data_t   imm_b;
    data_t   imm_j;
    data_t   imm_i;
    data_t   imm_s;
    data_t   alu_result;
    logic    jump_taken;
    addr_t   jump_target;
    addr_t   link_addr;
    addr_t   mem_addr;
    data_t   mem_data;
    logic    mem_we;
    mem_op_t mem_op;

    inst_decode u_decode (
        .inst_i      (inst_i),
        .reg_we_i    (reg_we_i),
        .alu_op_o    (alu_op),
        .alu_valid_o (alu_valid),
        .branch_en_o (branch_en),
        .jal_en_o    (jal_en),
        .jalr_en_o   (jalr_en),
        .load_en_o   (load_en),
        .store_en_o  (store_en),
        .write_en_o  (write_en),
        .link_sel_o  (link_sel),
        .funct3_o    (funct3),
        .imm_b_o     (imm_b),
        .imm_j_o     (imm_j),
        .imm_i_o     (imm_i),
        .imm_s_o     (imm_s)
    );

    int_alu u_alu (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .alu_op_i    (alu_op),
        .alu_valid_i (alu_valid),
        .result_o    (alu_result)
    );

    branch_unit u_branch (
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .pc_i        (inst_addr_i),
        .funct3_i    (funct3),
        .branch_en_i (branch_en),
        .jal_en_i    (jal_en),
        .jalr_en_i   (jalr_en),
        .imm_b_i     (imm_b),
        .imm_j_i     (imm_j),
        .imm_i_i     (imm_i),
        .taken_o     (jump_taken),
        .target_o    (jump_target),
        .link_o      (link_addr)
    );

    lsu_agu u_agu (
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .funct3_i    (funct3),
        .load_en_i   (load_en),
        .store_en_i  (store_en),
        .imm_i_i     (imm_i),
        .imm_s_i     (imm_s),
        .addr_o      (mem_addr),
        .wdata_o     (mem_data),
        .we_o        (mem_we),
        .op_o        (mem_op)
    );

    exe_mem_reg u_exe_mem (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .reg_waddr_i   (reg_waddr_i),
        .write_en_i    (write_en),
        .link_sel_i    (link_sel),
        .alu_result_i  (alu_result),
        .link_i        (link_addr),
        .mem_addr_i    (mem_addr),
        .mem_data_i    (mem_data),
        .mem_we_i      (mem_we),
        .mem_op_i      (mem_op),
        .jump_taken_i  (jump_taken),
        .jump_target_i (jump_target),
        .reg_waddr_o   (reg_waddr_o),
        .reg_we_o      (reg_we_o),
        .reg_wdata_o   (reg_wdata_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_o    (mem_data_o),
        .mem_we_o      (mem_we_o),
        .mem_op_o      (mem_op_o),
        .jump_addr_o   (jump_addr_o),
        .jump_enable_o (jump_enable_o)
    );

endmodule

/* tb_exe.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module tb_exe;
    import exe_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int N_ALU        = 300;
    localparam int N_LS         = 200;
    localparam int N_BJ         = 200;
    localparam int N_BAD        = 150;
    localparam int N_STREAM     = 1500;
    // every test needs one extra edge to drain the output register
    localparam int TOTAL_CYCLES = 5 + N_ALU + N_LS + N_BJ + N_BAD + N_STREAM + 5;

    typedef struct packed {
        raddr_t  waddr;
        logic    we;
        data_t   wdata;
        addr_t   maddr;
        data_t   mdata;
        logic    mwe;
        mem_op_t mop;
        addr_t   jaddr;
        logic    jen;
    } exp_t;

    logic    clk_i;
    logic    rst_i;
    data_t   op1_i;
    data_t   op2_i;
    logic    reg_we_i;
    raddr_t  reg_waddr_i;
    data_t   inst_i;
    addr_t   inst_addr_i;
    raddr_t  reg_waddr_o;
    logic    reg_we_o;
    data_t   reg_wdata_o;
    addr_t   mem_addr_o;
    data_t   mem_data_o;
    logic    mem_we_o;
    mem_op_t mem_op_o;
    addr_t   jump_addr_o;
    logic    jump_enable_o;

    exp_t exp_q[$];
    int   check_count;
    int   fail_count;
    int   tests_passed;
    int   tests_failed;
    int   seed_dummy;

    exe_top uut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .reg_we_i      (reg_we_i),
        .reg_waddr_i   (reg_waddr_i),
        .inst_i        (inst_i),
        .inst_addr_i   (inst_addr_i),
        .reg_waddr_o   (reg_waddr_o),
        .reg_we_o      (reg_we_o),
        .reg_wdata_o   (reg_wdata_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_o    (mem_data_o),
        .mem_we_o      (mem_we_o),
        .mem_op_o      (mem_op_o),
        .jump_addr_o   (jump_addr_o),
        .jump_enable_o (jump_enable_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // rv32i funct3 semantics for op and op-imm
    function automatic data_t alu_model(input logic [2:0] f3, input logic alt,
                                        input data_t a, input data_t b);
        data_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b110:  r = a | b;
            3'b111:  r = a & b;
            default: begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
        endcase
        return r;
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input data_t a, input data_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic exp_t model(input data_t inst, input data_t a, input data_t b,
                                   input addr_t pc, input logic we, input raddr_t wa);
        exp_t       e;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        data_t      imm_i;
        data_t      imm_s;
        data_t      imm_b;
        data_t      imm_j;
        logic       legal;
        logic       wr;
        data_t      res;
        e     = '0;
        opc   = inst[6:0];
        f3    = inst[14:12];
        f7    = inst[31:25];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        legal = 1'b1;
        wr    = 1'b0;
        res   = '0;
        case (opc)
            `OP_IMM: begin
                if (f3 == 3'b001)
                    legal = (f7 == `F7_BASE);
                else if (f3 == 3'b101)
                    legal = (f7 == `F7_BASE) || (f7 == `F7_ALT);
                wr  = we;
                res = alu_model(f3, f3 == 3'b101 && f7 == `F7_ALT, a, b);
            end
            `OP_REG: begin
                legal = (f7 == `F7_BASE) || (f7 == `F7_ALT && (f3 == 3'b000 || f3 == 3'b101));
                wr    = 1'b1;
                res   = alu_model(f3, f7 == `F7_ALT, a, b);
            end
            `OP_LUI, `OP_AUIPC: begin
                wr  = we;
                res = a + b;
            end
            `OP_LOAD: begin
                legal   = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
                wr      = 1'b1;     // loaded data comes later, zero here
                e.maddr = a + imm_i;
                e.mop   = (f3 == 3'b000) ? `MEM_LB  : (f3 == 3'b001) ? `MEM_LH :
                          (f3 == 3'b010) ? `MEM_LW  : (f3 == 3'b100) ? `MEM_LBU : `MEM_LHU;
            end
            `OP_STORE: begin
                legal   = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b010);
                e.maddr = a + imm_s;
                e.mdata = b;
                e.mwe   = 1'b1;
                e.mop   = (f3 == 3'b000) ? `MEM_SB : (f3 == 3'b001) ? `MEM_SH : `MEM_SW;
            end
            `OP_BRANCH: begin
                legal   = (f3 != 3'b010) && (f3 != 3'b011);
                e.jen   = branch_cond(f3, a, b);
                e.jaddr = pc + imm_b;
            end
            `OP_JAL: begin
                wr      = we;
                res     = pc + 32'd4;
                e.jen   = 1'b1;
                e.jaddr = pc + imm_j;
            end
            `OP_JALR: begin
                legal   = (f3 == 3'b000);
                wr      = we;
                res     = pc + 32'd4;
                e.jen   = 1'b1;
                e.jaddr = a + imm_i;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            e     = '0;
            e.mop = `MEM_NOP;
            return e;
        end
        e.we    = wr;
        e.waddr = wr ? wa : '0;
        e.wdata = wr ? res : '0;
        return e;
    endfunction

    function automatic data_t alu_inst();
        data_t      r;
        logic [2:0] f3;
        r  = $urandom;
        f3 = r[14:12];
        case ($urandom % 4)
            0: begin
                if (f3 == 3'b001)
                    return {`F7_BASE, r[24:7], `OP_IMM};
                if (f3 == 3'b101)
                    return {r[31] ? `F7_ALT : `F7_BASE, r[24:7], `OP_IMM};
                return {r[31:7], `OP_IMM};
            end
            1: begin
                if ((f3 == 3'b000 || f3 == 3'b101) && r[31])
                    return {`F7_ALT, r[24:7], `OP_REG};
                return {`F7_BASE, r[24:7], `OP_REG};
            end
            2:       return {r[31:7], `OP_LUI};
            default: return {r[31:7], `OP_AUIPC};
        endcase
    endfunction

    function automatic data_t ls_inst();
        data_t      r;
        logic [2:0] f3;
        int         pick;
        r    = $urandom;
        pick = $urandom % 5;
        if (r[0]) begin
            f3 = (pick < 3) ? pick[2:0] : pick[2:0] + 3'd1;    // 0,1,2,4,5
            return {r[31:15], f3, r[11:7], `OP_LOAD};
        end
        f3 = pick % 3;
        return {r[31:15], f3, r[11:7], `OP_STORE};
    endfunction

    function automatic data_t bj_inst();
        data_t      r;
        logic [2:0] f3;
        int         pick;
        r    = $urandom;
        pick = $urandom % 6;
        f3   = (pick < 2) ? pick[2:0] : pick[2:0] + 3'd2;
        case ($urandom % 4)
            0, 1:    return {r[31:15], f3, r[11:7], `OP_BRANCH};
            2:       return {r[31:7], `OP_JAL};
            default: return {r[31:15], 3'b000, r[11:7], `OP_JALR};
        endcase
    endfunction

    function automatic data_t bad_inst();
        data_t r;
        r = $urandom;
        case ($urandom % 4)
            0: return {7'b0000001, r[24:7], `OP_REG};                  // mul/div group
            1: return {r[31:25] | 7'b0000010, r[24:7], `OP_REG};
            2: return {r[31:25] | 7'b0000010, r[24:15], r[14] ? 3'b101 : 3'b001,
                       r[11:7], `OP_IMM};
            default: return {r[31:7], r[6:2], 2'b00};                  // not a 32-bit opcode
        endcase
    endfunction

    task automatic drive_one(input int kind);
        data_t  inst;
        data_t  a;
        data_t  b;
        addr_t  pc;
        int     pick;
        pick = (kind == 4) ? $urandom % 5 : kind;
        case (pick)
            0:       inst = alu_inst();
            1:       inst = ls_inst();
            2:       inst = bj_inst();
            3:       inst = bad_inst();
            default: inst = $urandom;
        endcase
        a  = $urandom;
        b  = $urandom;
        pc = $urandom & 32'hffff_fffc;
        if ($urandom % 4 == 0)
            b = a;      // hit the equal cases of branches and compares
        // operands as the decode stage would select them
        case (inst[6:0])
            `OP_IMM: b = {{20{inst[31]}}, inst[31:20]};
            `OP_LUI: begin
                a = '0;
                b = {inst[31:12], 12'b0};
            end
            `OP_AUIPC: begin
                a = pc;
                b = {inst[31:12], 12'b0};
            end
            default: ;
        endcase
        inst_i      = inst;
        op1_i       = a;
        op2_i       = b;
        inst_addr_i = pc;
        reg_we_i    = $urandom;
        reg_waddr_i = $urandom;
        exp_q.push_back(model(inst, a, b, pc, reg_we_i, reg_waddr_i));
    endtask

    task automatic check_val(input string tname, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
        check_count = check_count + 1;
        if (act !== exp) begin
            fail_count = fail_count + 1;
            $display("[FAIL] %s %s: expected %h, actual %h at %0t",
                     tname, field, exp, act, $time);
        end
    endtask

    task automatic compare_outputs(input string tname, input exp_t e);
        check_val(tname, "reg_waddr_o", e.waddr, reg_waddr_o);
        check_val(tname, "reg_we_o", e.we, reg_we_o);
        check_val(tname, "reg_wdata_o", e.wdata, reg_wdata_o);
        check_val(tname, "mem_addr_o", e.maddr, mem_addr_o);
        check_val(tname, "mem_data_o", e.mdata, mem_data_o);
        check_val(tname, "mem_we_o", e.mwe, mem_we_o);
        check_val(tname, "mem_op_o", e.mop, mem_op_o);
        check_val(tname, "jump_addr_o", e.jaddr, jump_addr_o);
        check_val(tname, "jump_enable_o", e.jen, jump_enable_o);
    endtask

    task automatic report_test(input string tname, input int fails_before);
        int n;
        n = fail_count - fails_before;
        if (n == 0)
            tests_passed = tests_passed + 1;
        else
            tests_failed = tests_failed + 1;
        $display("test %s finished with %0d mismatches", tname, n);
    endtask

    task automatic reset_test();
        exp_t zero;
        int   i;
        int   fails_before;
        zero         = '0;
        zero.mop     = `MEM_NOP;
        fails_before = fail_count;
        for (i = 0; i < 4; i = i + 1) begin
            @(posedge clk_i);
            #1;
            compare_outputs("reset", zero);
            if (i < 3) begin
                inst_i = $urandom;      // reset must win over any input
                op1_i  = $urandom;
                op2_i  = $urandom;
            end else begin
                rst_i  = 1'b0;
                inst_i = '0;
                op1_i  = '0;
                op2_i  = '0;
            end
        end
        @(posedge clk_i);
        #1;
        compare_outputs("reset", zero);
        report_test("reset", fails_before);
    endtask

    // one expectation per cycle, checked at the next edge
    task automatic run_test(input string tname, input int kind, input int n);
        exp_t e;
        int   i;
        int   fails_before;
        fails_before = fail_count;
        for (i = 0; i <= n; i = i + 1) begin
            @(posedge clk_i);
            #1;
            if (i < n)
                drive_one(kind);
            #1;     // registered outputs hold while the next inputs settle
            if (i > 0) begin
                e = exp_q.pop_front();
                compare_outputs(tname, e);
            end
        end
        report_test(tname, fails_before);
    endtask

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d ns", 2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        op1_i        = '0;
        op2_i        = '0;
        reg_we_i     = 1'b0;
        reg_waddr_i  = '0;
        inst_i       = '0;
        inst_addr_i  = '0;
        check_count  = 0;
        fail_count   = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed_dummy   = $urandom(32'h8b2a_6dfe);

        reset_test();
        run_test("alu_ops", 0, N_ALU);
        run_test("load_store", 1, N_LS);
        run_test("branch_jump", 2, N_BJ);
        run_test("illegal", 3, N_BAD);
        run_test("streaming", 4, N_STREAM);

        $display("tests passed %0d, tests failed %0d, mismatches %0d of %0d checks",
                 tests_passed, tests_failed, fail_count, check_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
exe_pkg.sv
inst_decode.sv
int_alu.sv
branch_unit.sv
lsu_agu.sv
exe_mem_reg.sv
exe_top.sv
tb_exe.sv

/* Bender.yml */
package:
  name: exe_stage

sources:
  - include_dirs:
      - .
    files:
      - exe_pkg.sv
      - inst_decode.sv
      - int_alu.sv
      - branch_unit.sv
      - lsu_agu.sv
      - exe_mem_reg.sv
      - exe_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exe.sv
